//--- hw/game_pkg.sv
`default_nettype none

package game_pkg;

    // ************************************************************************
    // Screen and sprite geometry
    // ************************************************************************

    localparam int screen_width  = 640;
    localparam int screen_height = 480;
    localparam int w_x           = 10;
    localparam int w_y           = 9;

    localparam int target_size   = 32;
    localparam int torpedo_size  = 8;

    // Game rules.
    localparam int n_targets      = 4;
    localparam int hits_per_level = 4;
    localparam int target_speed   = 2;    // Pixels per frame, each axis.
    localparam int torpedo_speed  = 2;
    localparam int w_v            = 6;    // Signed velocity width.

    // Slot i spawns at (64 + 128 i, 48 + 32 i).
    localparam int spawn_x0     = 64;
    localparam int spawn_x_step = 128;
    localparam int spawn_y0     = 48;
    localparam int spawn_y_step = 32;

    localparam int torpedo_start_x = 316;
    localparam int torpedo_start_y = 416;

    localparam int rgb_width = 3;
    localparam logic [rgb_width-1:0] rgb_background = 3'b000;
    localparam logic [rgb_width-1:0] rgb_target     = 3'b100;
    localparam logic [rgb_width-1:0] rgb_torpedo    = 3'b011;

    // ************************************************************************
    // Shared structs
    // ************************************************************************

    typedef struct packed {
        logic [w_x-1:0] left;
        logic [w_x-1:0] right;     // Exclusive.
        logic [w_y-1:0] top;
        logic [w_y-1:0] bottom;    // Exclusive.
    } sprite_box_t;

    typedef struct packed {
        logic                  load;
        logic [w_x-1:0]        x;
        logic [w_y-1:0]        y;
        logic signed [w_v-1:0] dx;
        logic signed [w_v-1:0] dy;
    } motion_load_t;

    typedef struct packed {
        logic [w_x-1:0] x;
        logic [w_y-1:0] y;
        logic           display_on;
    } pixel_t;

    // Bit 1 is left or down, bit 0 is right or up.
    typedef struct packed {
        logic [1:0] left_right;
        logic [1:0] down_up;
    } steer_t;

    // Spawn payload of one target slot, strobe low.
    function automatic motion_load_t spawn_load(input int slot);
        motion_load_t m;
        m.load = 1'b0;
        m.x    = w_x'(spawn_x0 + spawn_x_step * slot);
        m.y    = w_y'(spawn_y0 + spawn_y_step * slot);
        m.dx   = (slot % 2 == 0) ? w_v'(target_speed) : w_v'(-target_speed);
        m.dy   = w_v'(target_speed);    // All slots start downward.
        return m;
    endfunction

endpackage

`default_nettype wire

//--- hw/sprite_mover.sv
`default_nettype none

module sprite_mover
    import game_pkg::*;
#(
    parameter int size   = target_size,
    parameter int bounce = 1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         frame_move,
    input  motion_load_t load,
    output sprite_box_t  box,
    output logic         hit_wall,
    output logic         off_screen
);

    localparam int max_x   = screen_width - size;
    localparam int max_y   = screen_height - size;
    localparam bit reflect = bounce != 0;

    logic        [w_x-1:0] x;
    logic        [w_y-1:0] y;
    logic signed [w_v-1:0] dx;
    logic signed [w_v-1:0] dy;
    logic signed [w_v-1:0] vx;
    logic signed [w_v-1:0] vy;
    logic signed [w_x+1:0] next_x;    // Two spare bits catch both edges.
    logic signed [w_y+1:0] next_y;
    logic                  hit_x;
    logic                  hit_y;

    // A steered sprite takes its velocity from the payload on every move.
    assign vx = reflect ? dx : load.dx;
    assign vy = reflect ? dy : load.dy;

    assign next_x = $signed({2'b00, x}) + vx;
    assign next_y = $signed({2'b00, y}) + vy;

    assign hit_x = reflect && ((vx < 0 && next_x <= 0) || (vx > 0 && next_x >= max_x));
    assign hit_y = reflect && ((vy < 0 && next_y <= 0) || (vy > 0 && next_y >= max_y));

    // Position reloads from the payload while reset is held.
    always_ff @(posedge clk) begin
        if (rst || load.load) begin
            x  <= load.x;
            y  <= load.y;
            dx <= load.dx;
            dy <= load.dy;
        end else if (frame_move) begin
            if (hit_x) begin
                x  <= (vx < 0) ? '0 : w_x'(max_x);    // Clamp to the wall.
                dx <= -vx;
            end else begin
                x  <= next_x[w_x-1:0];
                dx <= vx;
            end
            if (hit_y) begin
                y  <= (vy < 0) ? '0 : w_y'(max_y);
                dy <= -vy;
            end else begin
                y  <= next_y[w_y-1:0];
                dy <= vy;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_wall <= 1'b0;
        end else begin
            hit_wall <= frame_move && !load.load && (hit_x || hit_y);
        end
    end

    assign box = '{left: x, right: x + w_x'(size), top: y, bottom: y + w_y'(size)};

    // Wrapped coordinates land above the limits too.
    assign off_screen = x > w_x'(max_x) || y > w_y'(max_y);

endmodule

`default_nettype wire

//--- hw/game_fsm.sv
`default_nettype none

module game_fsm
    import game_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         frame_tick,
    input  logic                         launch_key,
    input  steer_t                       steer,
    input  logic         [n_targets-1:0] spawn_req,
    input  logic                         collision,
    input  logic                         off_screen,
    output motion_load_t [n_targets-1:0] target_load,
    output motion_load_t                 torpedo_load,
    output logic                         torpedo_move
);

    typedef enum logic {
        st_ready,
        st_flying
    } state_t;

    state_t state;
    state_t state_next;
    logic   restart;

    // One axis of the key pad to a velocity. Both keys cancel.
    function automatic logic signed [w_v-1:0] axis_speed(input logic pos, input logic neg);
        if (pos && !neg) begin
            return w_v'(torpedo_speed);
        end else if (neg && !pos) begin
            return w_v'(-torpedo_speed);
        end
        return '0;
    endfunction

    assign restart = collision || off_screen;    // Torpedo back to start.

    always_comb begin
        state_next = state;
        if (restart) begin
            state_next = st_ready;
        end else if (state == st_ready && launch_key) begin
            state_next = st_flying;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_ready;
        end else begin
            state <= state_next;
        end
    end

    // Each slot always carries its spawn point.
    always_comb begin
        for (int i = 0; i < n_targets; i++) begin
            target_load[i]      = spawn_load(i);
            target_load[i].load = spawn_req[i] || collision;
        end
    end

    always_comb begin
        torpedo_load.load = restart;
        torpedo_load.x    = w_x'(torpedo_start_x);
        torpedo_load.y    = w_y'(torpedo_start_y);
        torpedo_load.dx   = axis_speed(steer.left_right[0], steer.left_right[1]);
        torpedo_load.dy   = axis_speed(steer.down_up[1], steer.down_up[0]);
    end

    assign torpedo_move = frame_tick && state == st_flying;

endmodule

`default_nettype wire

//--- hw/level_tracker.sv
`default_nettype none

module level_tracker
    import game_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [n_targets-1:0] hit_wall,
    input  logic                 collision,
    output logic [n_targets-1:0] target_enable,
    output logic [n_targets-1:0] spawn_req,
    output logic [15:0]          target_count
);

    localparam int w_active = $clog2(n_targets + 1);
    localparam int w_sum    = $clog2(hits_per_level + n_targets);

    logic [w_active-1:0] active;
    logic [w_sum-1:0]    group;       // Hits toward the next target.
    logic [w_sum-1:0]    new_hits;
    logic [w_sum-1:0]    group_sum;
    logic                group_done;
    logic [n_targets-1:0] enable_q;

    always_comb begin
        new_hits = '0;
        for (int i = 0; i < n_targets; i++) begin
            new_hits = new_hits + w_sum'(hit_wall[i]);
        end
        group_sum  = group + new_hits;
        group_done = group_sum >= w_sum'(hits_per_level);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            target_count <= '0;
            group        <= '0;
            active       <= w_active'(1);
            enable_q     <= n_targets'(1);
        end else begin
            enable_q <= target_enable;
            if (collision) begin
                target_count <= '0;
                group        <= '0;
                active       <= w_active'(1);
            end else begin
                target_count <= target_count + 16'(new_hits);
                group        <= group_done ? group_sum - w_sum'(hits_per_level) : group_sum;
                if (group_done && active < w_active'(n_targets)) begin
                    active <= active + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < n_targets; i++) begin
            target_enable[i] = i < int'(active);
        end
    end

    assign spawn_req = target_enable & ~enable_q;    // Newly enabled slots.

endmodule

`default_nettype wire

//--- hw/collision_detector.sv
`default_nettype none

module collision_detector
    import game_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  sprite_box_t [n_targets-1:0] target_box,
    input  sprite_box_t                 torpedo_box,
    input  logic        [n_targets-1:0] target_enable,
    output logic                        collision
);

    logic [n_targets-1:0] overlap;

    // Edges that only touch do not overlap.
    function automatic logic boxes_overlap(input sprite_box_t a, input sprite_box_t b);
        return a.left < b.right && b.left < a.right && a.top < b.bottom && b.top < a.bottom;
    endfunction

    always_comb begin
        for (int i = 0; i < n_targets; i++) begin
            overlap[i] = target_enable[i] && boxes_overlap(target_box[i], torpedo_box);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            collision <= 1'b0;
        end else begin
            collision <= |overlap;
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_mixer.sv
`default_nettype none

module pixel_mixer
    import game_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  pixel_t                      beam,
    input  sprite_box_t [n_targets-1:0] target_box,
    input  sprite_box_t                 torpedo_box,
    input  logic        [n_targets-1:0] target_enable,
    output logic        [rgb_width-1:0] rgb
);

    logic                 on_torpedo;
    logic [n_targets-1:0] on_target;
    logic [rgb_width-1:0] colour;

    function automatic logic covers(input sprite_box_t b, input pixel_t p);
        return p.x >= b.left && p.x < b.right && p.y >= b.top && p.y < b.bottom;
    endfunction

    assign on_torpedo = covers(torpedo_box, beam);

    always_comb begin
        for (int i = 0; i < n_targets; i++) begin
            on_target[i] = target_enable[i] && covers(target_box[i], beam);
        end
    end

    // Torpedo drawn over targets.
    always_comb begin
        if (!beam.display_on) begin
            colour = '0;
        end else if (on_torpedo) begin
            colour = rgb_torpedo;
        end else if (|on_target) begin
            colour = rgb_target;
        end else begin
            colour = rgb_background;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= '0;
        end else begin
            rgb <= colour;
        end
    end

endmodule

`default_nettype wire

//--- hw/game_top.sv
`default_nettype none

module game_top
    import game_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frame_tick,
    input  logic                 launch_key,
    input  steer_t               steer,
    input  pixel_t               beam,
    output logic [rgb_width-1:0] rgb,
    output logic [15:0]          target_count
);

    motion_load_t [n_targets-1:0] target_load;
    motion_load_t                 torpedo_load;
    sprite_box_t  [n_targets-1:0] target_box;
    sprite_box_t                  torpedo_box;
    logic         [n_targets-1:0] target_enable;
    logic         [n_targets-1:0] spawn_req;
    logic         [n_targets-1:0] hit_wall;
    logic                         torpedo_move;
    logic                         off_screen;
    logic                         collision;

    // ************************************************************************
    // Sprites
    // ************************************************************************

    for (genvar i = 0; i < n_targets; i++) begin : g_target
        sprite_mover #(
            .size   (target_size),
            .bounce (1)
        ) u_target (
            .clk        (clk),
            .rst        (rst),
            .frame_move (frame_tick & target_enable[i]),    // Idle slots stay put.
            .load       (target_load[i]),
            .box        (target_box[i]),
            .hit_wall   (hit_wall[i]),
            .off_screen ()
        );
    end

    sprite_mover #(
        .size   (torpedo_size),
        .bounce (0)
    ) u_torpedo (
        .clk        (clk),
        .rst        (rst),
        .frame_move (torpedo_move),
        .load       (torpedo_load),
        .box        (torpedo_box),
        .hit_wall   (),
        .off_screen (off_screen)
    );

    // ************************************************************************
    // Game control
    // ************************************************************************

    game_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .frame_tick   (frame_tick),
        .launch_key   (launch_key),
        .steer        (steer),
        .spawn_req    (spawn_req),
        .collision    (collision),
        .off_screen   (off_screen),
        .target_load  (target_load),
        .torpedo_load (torpedo_load),
        .torpedo_move (torpedo_move)
    );

    level_tracker u_level (
        .clk           (clk),
        .rst           (rst),
        .hit_wall      (hit_wall),
        .collision     (collision),
        .target_enable (target_enable),
        .spawn_req     (spawn_req),
        .target_count  (target_count)
    );

    collision_detector u_collision (
        .clk           (clk),
        .rst           (rst),
        .target_box    (target_box),
        .torpedo_box   (torpedo_box),
        .target_enable (target_enable),
        .collision     (collision)
    );

    pixel_mixer u_mixer (
        .clk           (clk),
        .rst           (rst),
        .beam          (beam),
        .target_box    (target_box),
        .torpedo_box   (torpedo_box),
        .target_enable (target_enable),
        .rgb           (rgb)
    );

endmodule

`default_nettype wire

//--- include/game_tb_model.svh
`ifndef game_tb_model_svh
`define game_tb_model_svh

// Position and velocity of one sprite in the model.
typedef struct packed {
    int x;
    int y;
    int dx;
    int dy;
} sprite_state_t;

function automatic sprite_state_t spawn_state(input int slot);
    sprite_state_t s;
    s.x  = spawn_x0 + spawn_x_step * slot;
    s.y  = spawn_y0 + spawn_y_step * slot;
    s.dx = (slot % 2 == 0) ? target_speed : -target_speed;    // Odd slots head left.
    s.dy = target_speed;
    return s;
endfunction

function automatic sprite_state_t torpedo_home();
    sprite_state_t s;
    s.x  = torpedo_start_x;
    s.y  = torpedo_start_y;
    s.dx = 0;
    s.dy = 0;
    return s;
endfunction

// One frame of a bouncing target. An edge that is reached stops it there.
function automatic sprite_state_t move_target(input sprite_state_t s);
    sprite_state_t n;
    n   = s;
    n.x = s.x + s.dx;
    n.y = s.y + s.dy;
    if ((s.dx < 0 && n.x <= 0) || (s.dx > 0 && n.x >= screen_width - target_size)) begin
        n.x  = (s.dx < 0) ? 0 : screen_width - target_size;
        n.dx = -s.dx;
    end
    if ((s.dy < 0 && n.y <= 0) || (s.dy > 0 && n.y >= screen_height - target_size)) begin
        n.y  = (s.dy < 0) ? 0 : screen_height - target_size;
        n.dy = -s.dy;
    end
    return n;
endfunction

// Both keys or none give no motion.
function automatic int key_speed(input logic pos, input logic neg);
    if (pos == neg) begin
        return 0;
    end
    return pos ? torpedo_speed : -torpedo_speed;
endfunction

function automatic sprite_state_t move_torpedo(input sprite_state_t s, input steer_t keys);
    sprite_state_t n;
    n   = s;
    n.x = s.x + key_speed(keys.left_right[0], keys.left_right[1]);
    n.y = s.y + key_speed(keys.down_up[1], keys.down_up[0]);
    return n;
endfunction

function automatic bit left_screen(input sprite_state_t p);
    return p.x < 0 || p.y < 0 || p.x > screen_width - torpedo_size
        || p.y > screen_height - torpedo_size;
endfunction

// Strict overlap of a target box and the torpedo box.
function automatic bit boxes_meet(input sprite_state_t t, input sprite_state_t p);
    return t.x < p.x + torpedo_size && p.x < t.x + target_size
        && t.y < p.y + torpedo_size && p.y < t.y + target_size;
endfunction

`endif

//--- verification/game_tb.sv
`default_nettype none

module game_tb
    import game_pkg::*;
();

    `include "game_tb_model.svh"

    localparam int     frame_cycles = 8;
    localparam int     n_steps      = 19;
    localparam steer_t keys_none    = '{left_right: 2'b00, down_up: 2'b00};
    localparam steer_t keys_up      = '{left_right: 2'b00, down_up: 2'b01};

    typedef enum {
        at_point,
        at_target,
        at_torpedo,
        blanked
    } probe_kind_t;

    // For at_target probes px is the slot.
    typedef struct {
        string                name;
        int                   frames;
        bit                   launch;
        steer_t               keys;
        probe_kind_t          kind;
        int                   px;
        int                   py;
        logic [rgb_width-1:0] colour;
        int                   count;
    } test_step_t;

    test_step_t steps [n_steps] = '{
        '{"reset_target",       0, 1'b0, keys_none, at_target,  0,   0,   rgb_target,     0},
        '{"reset_slot1_idle",   0, 1'b0, keys_none, at_point,   208, 96,  rgb_background, 0},
        '{"reset_blank",        0, 1'b0, keys_none, blanked,    80,  64,  3'b000,         0},
        '{"torpedo_at_start",   0, 1'b0, keys_none, at_torpedo, 0,   0,   rgb_torpedo,    0},
        '{"ready_holds",        10, 1'b0, keys_up,  at_point,   320, 420, rgb_torpedo,    0},
        '{"target_moving",      50, 1'b0, keys_none, at_target, 0,   0,   rgb_target,     0},
        '{"before_bottom",      139, 1'b0, keys_none, at_target, 0,  0,   rgb_target,     0},
        '{"bottom_hit",         1, 1'b0, keys_none, at_target,  0,   0,   rgb_target,     1},
        '{"after_bounce",       20, 1'b0, keys_none, at_target, 0,   0,   rgb_target,     1},
        '{"right_hit",          52, 1'b0, keys_none, at_target, 0,   0,   rgb_target,     2},
        '{"top_hit",            152, 1'b0, keys_none, at_target, 0,  0,   rgb_target,     3},
        '{"level_up",           152, 1'b0, keys_none, at_point, 208, 96,  rgb_target,     4},
        '{"torpedo_flying",     100, 1'b1, keys_up, at_torpedo, 0,   0,   rgb_torpedo,    6},
        '{"torpedo_off_top",    110, 1'b0, keys_up, at_point,   320, 420, rgb_torpedo,    7},
        '{"slot1_tracking",     0, 1'b0, keys_up,   at_target,  1,   0,   rgb_target,     7},
        '{"collision_restart",  29, 1'b1, keys_up,  at_point,   80,  64,  rgb_target,     0},
        '{"restart_slot1_idle", 0, 1'b0, keys_up,   at_point,   208, 96,  rgb_background, 0},
        '{"restart_ready",      5, 1'b0, keys_up,   at_point,   320, 420, rgb_torpedo,    0},
        '{"restart_target",     0, 1'b0, keys_none, at_target,  0,   0,   rgb_target,     0}
    };

    logic                 clk;
    logic                 rst;
    logic                 frame_tick;
    logic                 launch_key;
    steer_t               steer;
    pixel_t               beam;
    logic [rgb_width-1:0] rgb;
    logic [15:0]          target_count;

    int cycle_count = 0;
    int cycle_limit;

    // Model of the game.
    sprite_state_t target_m [n_targets];
    sprite_state_t torpedo_m;
    int            active_m;
    int            group_m;
    int            count_m;
    bit            flying_m;

    game_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .frame_tick   (frame_tick),
        .launch_key   (launch_key),
        .steer        (steer),
        .beam         (beam),
        .rgb          (rgb),
        .target_count (target_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout: no end of the test table after %0d cycles",
                                        cycle_count));
        end
    end

    // ************************************************************************
    // Checking
    // ************************************************************************

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            stop_with_failure($sformatf("FAILED %s: expected %0d, actual %0d",
                                        name, expected, actual));
        end
    endtask

    function automatic int run_limit();
        int total;
        total = 0;
        foreach (steps[i]) begin
            total += steps[i].frames;
        end
        return total * frame_cycles + 200;
    endfunction

    // State after reset and after a collision.
    task automatic restart_model();
        for (int i = 0; i < n_targets; i++) begin
            target_m[i] = spawn_state(i);
        end
        torpedo_m = torpedo_home();
        active_m  = 1;
        group_m   = 0;
        count_m   = 0;
        flying_m  = 1'b0;
    endtask

    task automatic advance_model();
        sprite_state_t moved;
        int            hits;
        bit            crash;
        hits  = 0;
        crash = 1'b0;
        for (int i = 0; i < active_m; i++) begin
            moved = move_target(target_m[i]);
            if (moved.dx != target_m[i].dx || moved.dy != target_m[i].dy) begin
                hits++;    // Flipped velocity.
            end
            target_m[i] = moved;
        end
        if (flying_m) begin
            torpedo_m = move_torpedo(torpedo_m, steer);
        end
        for (int i = 0; i < active_m; i++) begin
            if (!left_screen(torpedo_m) && boxes_meet(target_m[i], torpedo_m)) begin
                crash = 1'b1;
            end
        end
        if (crash) begin
            restart_model();    // Hits of this frame are lost.
        end else begin
            count_m += hits;
            group_m += hits;
            if (group_m >= hits_per_level) begin
                group_m -= hits_per_level;
                if (active_m < n_targets) begin
                    target_m[active_m] = spawn_state(active_m);
                    active_m++;
                end
            end
            if (left_screen(torpedo_m)) begin
                torpedo_m = torpedo_home();
                flying_m  = 1'b0;
            end
        end
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    task automatic run_frame(input string name);
        @(posedge clk);
        frame_tick <= 1'b1;
        @(posedge clk);
        frame_tick <= 1'b0;
        repeat (frame_cycles - 2) @(posedge clk);
        @(negedge clk);
        advance_model();
        expect_value(name, count_m, int'(target_count));
    endtask

    task automatic probe_pixel(input string name, input int px, input int py, input bit on,
                               input int colour);
        @(posedge clk);
        beam <= '{x: w_x'(px), y: w_y'(py), display_on: on};
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_value(name, colour, int'(rgb));
    endtask

    task automatic apply_step(input test_step_t s);
        int px;
        int py;
        @(posedge clk);
        steer      <= s.keys;
        launch_key <= s.launch;
        @(posedge clk);
        launch_key <= 1'b0;
        if (s.launch) begin
            flying_m = 1'b1;
        end
        for (int f = 0; f < s.frames; f++) begin
            run_frame(s.name);
        end
        px = s.px;
        py = s.py;
        case (s.kind)
            at_target: begin
                px = target_m[s.px].x + target_size / 2;
                py = target_m[s.px].y + target_size / 2;
            end
            at_torpedo: begin
                px = torpedo_m.x + torpedo_size / 2;
                py = torpedo_m.y + torpedo_size / 2;
            end
            default: begin
            end
        endcase
        probe_pixel(s.name, px, py, s.kind != blanked, int'(s.colour));
        expect_value(s.name, s.count, int'(target_count));
    endtask

    initial begin
        rst         = 1'b1;
        frame_tick  = 1'b0;
        launch_key  = 1'b0;
        steer       = keys_none;
        beam        = '0;
        cycle_limit = run_limit();
        restart_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hw/game_pkg.sv
hw/sprite_mover.sv
hw/game_fsm.sv
hw/level_tracker.sv
hw/collision_detector.sv
hw/pixel_mixer.sv
hw/game_top.sv
verification/game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the game testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module game_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vgame_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
